// ==== hdl/csr_defines.svh ====
// --------------------------------------------------------------------------
// Shared sizes and CSR addresses for the SIMT core CSR unit.
// Include this file in any file that needs lane, warp or address widths.
// --------------------------------------------------------------------------

`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

// Warp geometry
`define CSR_NUM_LANES      4
`define CSR_NUM_WARPS      4
`define CSR_NW_BITS        2
`define CSR_NT_BITS        2

// Core number folded into the hart ID
`define CSR_CORE_ID        3

`define CSR_UUID_BITS      8
`define CSR_ADDR_BITS      12
`define CSR_ZIMM_BITS      5

// Per-thread identification
`define CSR_ADDR_THREAD_ID 12'hCC0
`define CSR_ADDR_WARP_ID   12'hCC1
`define CSR_ADDR_MHARTID   12'hF14

// Read/write scratch registers
`define CSR_ADDR_MSCRATCH  12'h340
`define CSR_ADDR_MEPC      12'h341

// Counters, low and high halves
`define CSR_ADDR_MCYCLE    12'hB00
`define CSR_ADDR_MINSTRET  12'hB02
`define CSR_ADDR_MSTALL    12'hB03
`define CSR_ADDR_MCYCLEH   12'hB80
`define CSR_ADDR_MINSTRETH 12'hB82
`define CSR_ADDR_MSTALLH   12'hB83

`endif

// ==== hdl/csr_pkg.sv ====
// --------------------------------------------------------------------------
// Types shared by the CSR unit and its testbench: the op code and the
// request and response records of the valid/ready streams.
// --------------------------------------------------------------------------

`include "csr_defines.svh"

package csr_pkg;

    // Encoding 0 is left undefined
    typedef enum logic [1:0] {
        CSR_OP_RW = 2'd1,
        CSR_OP_RS = 2'd2,
        CSR_OP_RC = 2'd3
    } csr_op_e;

    // Immediate field as carried by the decoder, zimm above the address
    typedef struct packed {
        logic [`CSR_ZIMM_BITS-1:0] zimm;
        logic [`CSR_ADDR_BITS-1:0] addr;
    } csr_imm_t;

    typedef logic [`CSR_NUM_LANES-1:0][31:0] csr_lane_data_t;

    typedef struct packed {
        logic [`CSR_UUID_BITS-1:0] uuid;
        logic [`CSR_NW_BITS-1:0]   wid;
        logic [`CSR_NUM_LANES-1:0] tmask;
        logic [31:0]               pc;
        logic [4:0]                rd;
        logic                      wb;
        csr_op_e                   op;
        logic                      use_imm;
        csr_imm_t                  imm;
        csr_lane_data_t            rs1_data;
    } csr_req_t;

    typedef struct packed {
        logic [`CSR_UUID_BITS-1:0] uuid;
        logic [`CSR_NW_BITS-1:0]   wid;
        logic [`CSR_NUM_LANES-1:0] tmask;
        logic [31:0]               pc;
        logic [4:0]                rd;
        logic                      wb;
        csr_lane_data_t            data;
    } csr_rsp_t;

endpackage

// ==== hdl/csr_issue_ctrl.sv ====
// --------------------------------------------------------------------------
// Issue control for the CSR unit. Holds the head request while its warp
// still has instructions in flight or the response buffer is full, and
// unlocks the warp in the cycle the request is taken.
// --------------------------------------------------------------------------

`timescale 1ns/100ps

`include "csr_defines.svh"

module csr_issue_ctrl (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      req_valid,
    input  logic [`CSR_NW_BITS-1:0]   req_wid,
    input  logic [`CSR_NUM_WARPS-1:0] pending_mask,
    input  logic                      has_space,
    output logic                      req_ready,
    output logic                      accept,
    output logic                      drain_stall,
    output logic                      unlock_valid,
    output logic [`CSR_NW_BITS-1:0]   unlock_wid
);

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_DRAIN = 2'd1,
        ST_FULL  = 2'd2
    } state_e;

    state_e state_q;
    state_e state_n;
    logic   warp_pending;
    logic   do_issue;
    logic   hold_pending;
    logic   hold_full;

    assign warp_pending = pending_mask[req_wid];

    // Each cycle is exactly one of issue, drain hold or full hold (or idle)
    assign do_issue     = req_valid && !warp_pending && has_space;
    assign hold_pending = req_valid && warp_pending;
    assign hold_full    = req_valid && !warp_pending && !has_space;

    assign req_ready   = has_space && !warp_pending;
    assign accept      = do_issue;
    assign drain_stall = hold_pending;

    assign unlock_valid = do_issue;
    assign unlock_wid   = req_wid;

    always_comb begin
        state_n = ST_IDLE;
        if (hold_pending) begin
            state_n = ST_DRAIN;
        end else if (hold_full) begin
            state_n = ST_FULL;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_n;
        end
    end

    // A held request must not switch warps before it is taken
    a_held_wid_stable: assert property (@(posedge clk) disable iff (rst)
        (state_q != ST_IDLE) && req_valid |-> $stable(req_wid));

endmodule

// ==== hdl/csr_counters.sv ====
// --------------------------------------------------------------------------
// 64-bit event counters read through the CSR file: cycles since reset,
// retired instructions and cycles spent waiting for a warp to drain.
// --------------------------------------------------------------------------

`timescale 1ns/100ps

module csr_counters (
    input  logic        clk,
    input  logic        rst,
    input  logic        commit_retire,
    input  logic        drain_stall,
    output logic [63:0] mcycle,
    output logic [63:0] minstret,
    output logic [63:0] mstall
);

    localparam int NUM_CNT  = 3;
    localparam int CNT_CYC  = 0;
    localparam int CNT_RET  = 1;
    localparam int CNT_STL  = 2;

    logic [NUM_CNT-1:0] inc;
    logic [63:0]        cnt_q [NUM_CNT];

    // Cycle counter runs on every edge out of reset
    assign inc[CNT_CYC] = 1'b1;
    assign inc[CNT_RET] = commit_retire;
    assign inc[CNT_STL] = drain_stall;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_CNT; i++) begin
                cnt_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_CNT; i++) begin
                if (inc[i]) begin
                    cnt_q[i] <= cnt_q[i] + 64'd1;
                end
            end
        end
    end

    assign mcycle   = cnt_q[CNT_CYC];
    assign minstret = cnt_q[CNT_RET];
    assign mstall   = cnt_q[CNT_STL];

endmodule

// ==== hdl/csr_file.sv ====
// --------------------------------------------------------------------------
// CSR storage and read mux. Builds per-lane thread and hart IDs, selects
// the value to return and applies RW/RS/RC to MSCRATCH and MEPC on accept.
// --------------------------------------------------------------------------

`timescale 1ns/100ps

`include "csr_defines.svh"

module csr_file import csr_pkg::*; (
    input  logic           clk,
    input  logic           rst,
    input  logic           accept,
    input  csr_req_t       req,
    input  logic [63:0]    mcycle,
    input  logic [63:0]    minstret,
    input  logic [63:0]    mstall,
    output csr_lane_data_t read_data
);

    logic [`CSR_ADDR_BITS-1:0] addr;
    logic [`CSR_ZIMM_BITS-1:0] zimm;
    csr_lane_data_t            tid;
    csr_lane_data_t            hart_id;
    logic [31:0]               scalar;
    logic [31:0]               mscratch_q;
    logic [31:0]               mepc_q;
    logic [31:0]               old_val;
    logic [31:0]               src;
    logic [31:0]               wdata;
    logic                      wr_en;

    assign addr = req.imm.addr;
    assign zimm = req.imm.zimm;

    always_comb begin
        for (int i = 0; i < `CSR_NUM_LANES; i++) begin
            tid[i]     = 32'(i);
            hart_id[i] = (32'(`CSR_CORE_ID) << (`CSR_NW_BITS + `CSR_NT_BITS))
                       + (32'(req.wid) << `CSR_NT_BITS) + tid[i];
        end
    end

    // Values that are the same in every lane
    always_comb begin
        case (addr)
            `CSR_ADDR_WARP_ID:   scalar = 32'(req.wid);
            `CSR_ADDR_MSCRATCH:  scalar = mscratch_q;
            `CSR_ADDR_MEPC:      scalar = mepc_q;
            `CSR_ADDR_MCYCLE:    scalar = mcycle[31:0];
            `CSR_ADDR_MCYCLEH:   scalar = mcycle[63:32];
            `CSR_ADDR_MINSTRET:  scalar = minstret[31:0];
            `CSR_ADDR_MINSTRETH: scalar = minstret[63:32];
            `CSR_ADDR_MSTALL:    scalar = mstall[31:0];
            `CSR_ADDR_MSTALLH:   scalar = mstall[63:32];
            default:             scalar = '0;
        endcase
    end

    always_comb begin
        case (addr)
            `CSR_ADDR_THREAD_ID: read_data = tid;
            `CSR_ADDR_MHARTID:   read_data = hart_id;
            default:             read_data = {`CSR_NUM_LANES{scalar}};
        endcase
    end

    // Read-modify-write source comes from lane 0 or the immediate
    assign src     = req.use_imm ? 32'(zimm) : req.rs1_data[0];
    assign old_val = (addr == `CSR_ADDR_MEPC) ? mepc_q : mscratch_q;
    assign wr_en   = accept && ((req.op == CSR_OP_RW) || (src != '0));

    always_comb begin
        case (req.op)
            CSR_OP_RW: wdata = src;
            CSR_OP_RS: wdata = old_val | src;
            default:   wdata = old_val & ~src;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mscratch_q <= '0;
            mepc_q     <= '0;
        end else if (wr_en) begin
            if (addr == `CSR_ADDR_MSCRATCH) begin
                mscratch_q <= wdata;
            end
            if (addr == `CSR_ADDR_MEPC) begin
                mepc_q <= wdata;
            end
        end
    end

    a_op_defined: assert property (@(posedge clk) disable iff (rst)
        accept |-> (req.op inside {CSR_OP_RW, CSR_OP_RS, CSR_OP_RC}));

endmodule

// ==== hdl/csr_rsp_buffer.sv ====
// --------------------------------------------------------------------------
// Two-entry elastic buffer on the response path. The output entry is a
// register and a skid entry catches a push while the output is stalled.
// --------------------------------------------------------------------------

`timescale 1ns/100ps

module csr_rsp_buffer import csr_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     push,
    input  csr_rsp_t push_data,
    output logic     has_space,
    output logic     rsp_valid,
    output csr_rsp_t rsp,
    input  logic     rsp_ready
);

    logic     out_valid_q;
    logic     skid_valid_q;
    logic     out_valid_n;
    logic     skid_valid_n;
    logic     space_q;
    logic     pop;
    logic     load_out_push;
    logic     load_out_skid;
    logic     load_skid;
    csr_rsp_t out_q;
    csr_rsp_t skid_q;

    assign pop = out_valid_q && rsp_ready;

    always_comb begin
        out_valid_n   = out_valid_q;
        skid_valid_n  = skid_valid_q;
        load_out_push = 1'b0;
        load_out_skid = 1'b0;
        load_skid     = 1'b0;
        if (pop) begin
            if (skid_valid_q) begin
                load_out_skid = 1'b1;
                skid_valid_n  = push;
                load_skid     = push;
            end else begin
                out_valid_n   = push;
                load_out_push = push;
            end
        end else if (push) begin
            if (out_valid_q) begin
                skid_valid_n = 1'b1;
                load_skid    = 1'b1;
            end else begin
                out_valid_n   = 1'b1;
                load_out_push = 1'b1;
            end
        end
    end

    // Space flag is registered so it stays low through reset
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_q  <= 1'b0;
            skid_valid_q <= 1'b0;
            space_q      <= 1'b0;
        end else begin
            out_valid_q  <= out_valid_n;
            skid_valid_q <= skid_valid_n;
            space_q      <= !(out_valid_n && skid_valid_n);
        end
    end

    always_ff @(posedge clk) begin
        if (load_out_skid) begin
            out_q <= skid_q;
        end else if (load_out_push) begin
            out_q <= push_data;
        end
        if (load_skid) begin
            skid_q <= push_data;
        end
    end

    assign has_space = space_q;
    assign rsp_valid = out_valid_q;
    assign rsp       = out_q;

    a_no_push_full: assert property (@(posedge clk) disable iff (rst)
        push |-> !(out_valid_q && skid_valid_q));

    a_rsp_stable: assert property (@(posedge clk) disable iff (rst)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp));

endmodule

// ==== hdl/csr_unit.sv ====
// --------------------------------------------------------------------------
// CSR execution block of the SIMT core. Takes CSR requests on a
// valid/ready stream, waits for the warp to drain, reads and updates the
// CSR per lane and returns the result through a two-entry buffer.
// --------------------------------------------------------------------------

`timescale 1ns/100ps

`include "csr_defines.svh"

module csr_unit import csr_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      req_valid,
    input  csr_req_t                  req,
    output logic                      req_ready,
    output logic                      rsp_valid,
    output csr_rsp_t                  rsp,
    input  logic                      rsp_ready,
    input  logic [`CSR_NUM_WARPS-1:0] pending_mask,
    input  logic                      commit_retire,
    output logic                      unlock_valid,
    output logic [`CSR_NW_BITS-1:0]   unlock_wid
);

    logic           accept;
    logic           has_space;
    logic           drain_stall;
    logic [63:0]    mcycle;
    logic [63:0]    minstret;
    logic [63:0]    mstall;
    csr_lane_data_t read_data;
    csr_rsp_t       push_data;

    csr_issue_ctrl i_csr_issue_ctrl (
        .clk          (clk),
        .rst          (rst),
        .req_valid    (req_valid),
        .req_wid      (req.wid),
        .pending_mask (pending_mask),
        .has_space    (has_space),
        .req_ready    (req_ready),
        .accept       (accept),
        .drain_stall  (drain_stall),
        .unlock_valid (unlock_valid),
        .unlock_wid   (unlock_wid)
    );

    csr_counters i_csr_counters (
        .clk           (clk),
        .rst           (rst),
        .commit_retire (commit_retire),
        .drain_stall   (drain_stall),
        .mcycle        (mcycle),
        .minstret      (minstret),
        .mstall        (mstall)
    );

    csr_file i_csr_file (
        .clk       (clk),
        .rst       (rst),
        .accept    (accept),
        .req       (req),
        .mcycle    (mcycle),
        .minstret  (minstret),
        .mstall    (mstall),
        .read_data (read_data)
    );

    // Request fields travel with the read data to the commit stage
    assign push_data = '{uuid: req.uuid, wid: req.wid, tmask: req.tmask, pc: req.pc,
                         rd: req.rd, wb: req.wb, data: read_data};

    csr_rsp_buffer i_csr_rsp_buffer (
        .clk       (clk),
        .rst       (rst),
        .push      (accept),
        .push_data (push_data),
        .has_space (has_space),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .rsp_ready (rsp_ready)
    );

endmodule

// ==== tests/csr_unit_tb.sv ====
// --------------------------------------------------------------------------
// Self-checking testbench for the CSR unit. Drives random CSR requests,
// predicts each response from a reference model and checks the responses,
// req_ready and unlock with assertions. Run it through the Makefile.
// --------------------------------------------------------------------------

`timescale 1ns/100ps

`include "csr_defines.svh"

module csr_unit_tb import csr_pkg::*; ();

    localparam int CLK_PERIOD      = 40;
    localparam int RESET_CYCLES    = 16;
    localparam int SEED            = 61924;
    localparam int N_ID            = 8;
    localparam int N_RMW           = 24;
    localparam int N_BP            = 20;
    localparam int NUM_REQS        = N_ID + N_RMW + 6 + 3 + 6 + N_BP;
    localparam int WATCHDOG_CYCLES = NUM_REQS * 40 + RESET_CYCLES + 100;

    logic                      clk = 1'b0;
    logic                      rst;
    logic                      req_valid;
    csr_req_t                  req;
    logic                      req_ready;
    logic                      rsp_valid;
    csr_rsp_t                  rsp;
    logic                      rsp_ready;
    logic [`CSR_NUM_WARPS-1:0] pending_mask;
    logic                      commit_retire;
    logic                      unlock_valid;
    logic [`CSR_NW_BITS-1:0]   unlock_wid;

    // Reference model state
    logic [31:0] m_scratch;
    logic [31:0] m_epc;
    logic [63:0] m_cycle;
    logic [63:0] m_instret;
    logic [63:0] m_stall;
    csr_rsp_t    exp_q [$];
    string       name_q [$];
    bit          last_accept;
    bit          bp_on;
    bit          was_live;
    bit          seen_reset;
    string       cur_name = "reset";
    logic [7:0]  next_uuid = 8'd0;

    // Taken at each rising edge and checked at the falling edge after it
    bit                      hs_fire;
    bit                      hs_empty;
    csr_rsp_t                hs_exp;
    csr_rsp_t                hs_act;
    string                   hs_name;
    bit                      ready_ok = 1'b1;
    bit                      ready_exp;
    bit                      ready_act;
    bit                      unlock_ok = 1'b1;
    bit                      unlock_exp;
    logic                    unlock_act;
    logic [`CSR_NW_BITS-1:0] unlock_wid_exp;
    logic [`CSR_NW_BITS-1:0] unlock_wid_act;
    bit                      quiet_ok = 1'b1;
    string                   chk_name;

    csr_unit i_csr_unit (
        .clk           (clk),
        .rst           (rst),
        .req_valid     (req_valid),
        .req           (req),
        .req_ready     (req_ready),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp),
        .rsp_ready     (rsp_ready),
        .pending_mask  (pending_mask),
        .commit_retire (commit_retire),
        .unlock_valid  (unlock_valid),
        .unlock_wid    (unlock_wid)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_with_failure(string what);
        $display("%s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    function automatic csr_rsp_t expected_response(csr_req_t r);
        csr_rsp_t    e;
        logic [31:0] v;
        e.uuid  = r.uuid;
        e.wid   = r.wid;
        e.tmask = r.tmask;
        e.pc    = r.pc;
        e.rd    = r.rd;
        e.wb    = r.wb;
        case (r.imm.addr)
            `CSR_ADDR_WARP_ID:   v = 32'(r.wid);
            `CSR_ADDR_MSCRATCH:  v = m_scratch;
            `CSR_ADDR_MEPC:      v = m_epc;
            `CSR_ADDR_MCYCLE:    v = m_cycle[31:0];
            `CSR_ADDR_MCYCLEH:   v = m_cycle[63:32];
            `CSR_ADDR_MINSTRET:  v = m_instret[31:0];
            `CSR_ADDR_MINSTRETH: v = m_instret[63:32];
            `CSR_ADDR_MSTALL:    v = m_stall[31:0];
            `CSR_ADDR_MSTALLH:   v = m_stall[63:32];
            default:             v = 32'd0;
        endcase
        for (int i = 0; i < `CSR_NUM_LANES; i++) begin
            if (r.imm.addr == `CSR_ADDR_THREAD_ID) begin
                e.data[i] = 32'(i);
            end else if (r.imm.addr == `CSR_ADDR_MHARTID) begin
                e.data[i] = (32'(`CSR_CORE_ID) << (`CSR_NW_BITS + `CSR_NT_BITS))
                          + (32'(r.wid) << `CSR_NT_BITS) + 32'(i);
            end else begin
                e.data[i] = v;
            end
        end
        return e;
    endfunction

    function automatic void apply_write(csr_req_t r);
        logic [31:0] src;
        logic [31:0] old;
        logic [31:0] nv;
        src = r.use_imm ? 32'(r.imm.zimm) : r.rs1_data[0];
        if (r.op != CSR_OP_RW && src == 32'd0) begin
            return;
        end
        old = (r.imm.addr == `CSR_ADDR_MEPC) ? m_epc : m_scratch;
        case (r.op)
            CSR_OP_RW: nv = src;
            CSR_OP_RS: nv = old | src;
            default:   nv = old & ~src;
        endcase
        if (r.imm.addr == `CSR_ADDR_MSCRATCH) begin
            m_scratch = nv;
        end else if (r.imm.addr == `CSR_ADDR_MEPC) begin
            m_epc = nv;
        end
    endfunction

    // Everything is read before the DUT registers update at this edge
    always @(posedge clk) begin : model
        bit accepted;
        accepted       = (req_valid === 1'b1) && (req_ready === 1'b1);
        chk_name       = cur_name;
        ready_exp      = (exp_q.size() < 2) && !pending_mask[req.wid];
        ready_act      = (req_ready === 1'b1);
        ready_ok       = !was_live || rst || (ready_act == ready_exp);
        unlock_exp     = accepted;
        unlock_act     = unlock_valid;
        unlock_wid_exp = req.wid;
        unlock_wid_act = unlock_wid;
        unlock_ok      = (unlock_valid === accepted)
                       && (!accepted || unlock_wid === req.wid);
        quiet_ok  = !(rst && seen_reset)
                  || (req_ready === 1'b0 && rsp_valid === 1'b0 && unlock_valid === 1'b0);
        hs_fire   = (rsp_valid === 1'b1) && (rsp_ready === 1'b1);
        hs_empty  = (exp_q.size() == 0);
        if (hs_fire && !hs_empty) begin
            hs_exp  = exp_q.pop_front();
            hs_name = name_q.pop_front();
            hs_act  = rsp;
        end
        if (accepted) begin
            exp_q.push_back(expected_response(req));
            name_q.push_back(cur_name);
            apply_write(req);
        end
        last_accept = accepted;
        if (rst) begin
            m_scratch = 32'd0;
            m_epc     = 32'd0;
            m_cycle   = 64'd0;
            m_instret = 64'd0;
            m_stall   = 64'd0;
        end else begin
            m_cycle = m_cycle + 64'd1;
            if (commit_retire) begin
                m_instret = m_instret + 64'd1;
            end
            if (req_valid && pending_mask[req.wid]) begin
                m_stall = m_stall + 64'd1;
            end
        end
        was_live   = !rst;
        seen_reset = seen_reset || rst;
    end

    a_rsp_expected: assert property (@(negedge clk) hs_fire |-> !hs_empty)
        else stop_with_failure("A response arrived with no request outstanding");

    a_rsp_value: assert property (@(negedge clk) hs_fire && !hs_empty |-> hs_act === hs_exp)
        else stop_with_failure($sformatf("Mismatch in %s: expected %h, actual %h",
                                         hs_name, hs_exp, hs_act));

    a_req_ready: assert property (@(negedge clk) ready_ok)
        else stop_with_failure($sformatf("Mismatch in %s: expected req_ready %0b, actual %0b",
                                         chk_name, ready_exp, ready_act));

    a_unlock: assert property (@(negedge clk) unlock_ok)
        else stop_with_failure($sformatf(
            "Mismatch in %s: expected unlock %0b wid %0d, actual unlock %0b wid %0d",
            chk_name, unlock_exp, unlock_wid_exp, unlock_act, unlock_wid_act));

    a_reset_quiet: assert property (@(negedge clk) quiet_ok)
        else stop_with_failure("An output handshake was active during reset");

    function automatic csr_op_e random_op();
        return csr_op_e'(2'($urandom_range(1, 3)));
    endfunction

    function automatic csr_req_t make_req(logic [11:0] addr, csr_op_e op, logic use_imm);
        csr_req_t r;
        r.uuid     = next_uuid;
        next_uuid  = next_uuid + 8'd1;
        r.wid      = 2'($urandom_range(0, 3));
        r.tmask    = 4'($urandom_range(1, 15));
        r.pc       = $urandom;
        r.rd       = 5'($urandom_range(0, 31));
        r.wb       = 1'($urandom_range(0, 1));
        r.op       = op;
        r.use_imm  = use_imm;
        r.imm.zimm = 5'($urandom_range(0, 31));
        r.imm.addr = addr;
        for (int i = 0; i < `CSR_NUM_LANES; i++) begin
            r.rs1_data[i] = $urandom;
        end
        return r;
    endfunction

    task automatic wait_accept();
        do begin
            @(negedge clk);
        end while (!last_accept);
        req_valid = 1'b0;
    endtask

    task automatic send_req(csr_req_t r, string name);
        cur_name  = name;
        req       = r;
        req_valid = 1'b1;
        wait_accept();
    endtask

    // Holds the warp pending for n cycles before it may issue
    task automatic send_held(csr_req_t r, string name, int n);
        cur_name              = name;
        req                   = r;
        req_valid             = 1'b1;
        pending_mask[r.wid]   = 1'b1;
        repeat (n) @(negedge clk);
        pending_mask = '0;
        wait_accept();
    endtask

    task automatic idle(int n);
        repeat (n) @(negedge clk);
    endtask

    always @(negedge clk) begin
        commit_retire = 1'($urandom_range(0, 1));
        rsp_ready     = bp_on ? ($urandom_range(0, 2) != 0) : 1'b1;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        stop_with_failure("The run timed out before all responses came back");
    end

    initial begin
        csr_req_t    r;
        logic [11:0] addr;
        logic [11:0] bp_addr [8];
        void'($urandom(SEED));
        bp_addr = '{`CSR_ADDR_MSCRATCH, `CSR_ADDR_MEPC, `CSR_ADDR_THREAD_ID,
                    `CSR_ADDR_MHARTID, `CSR_ADDR_MCYCLE, `CSR_ADDR_MINSTRET,
                    `CSR_ADDR_MSTALL, 12'h0FF};
        rst           = 1'b1;
        req_valid     = 1'b0;
        req           = '0;
        rsp_ready     = 1'b1;
        pending_mask  = '0;
        commit_retire = 1'b0;
        bp_on         = 1'b0;
        idle(RESET_CYCLES);
        rst = 1'b0;
        idle(3);

        for (int k = 0; k < N_ID; k++) begin
            case ($urandom_range(0, 2))
                0:       addr = `CSR_ADDR_THREAD_ID;
                1:       addr = `CSR_ADDR_WARP_ID;
                default: addr = `CSR_ADDR_MHARTID;
            endcase
            send_req(make_req(addr, CSR_OP_RS, 1'b1), "id_read");
        end

        // Back to back, so each write is seen by the next request
        for (int k = 0; k < N_RMW; k++) begin
            addr = (k % 2 == 0) ? `CSR_ADDR_MSCRATCH : `CSR_ADDR_MEPC;
            r = make_req(addr, random_op(), 1'($urandom_range(0, 1)));
            if (k % 4 == 3) begin
                r.imm.zimm     = '0;
                r.rs1_data[0]  = '0;
            end
            send_req(r, "scratch_rmw");
        end

        send_req(make_req(`CSR_ADDR_MCYCLE, CSR_OP_RW, 1'b0), "read_only_write");
        send_req(make_req(`CSR_ADDR_MINSTRET, CSR_OP_RW, 1'b0), "read_only_write");
        send_req(make_req(12'h123, CSR_OP_RW, 1'b0), "unlisted_write");
        send_req(make_req(12'h7C0, CSR_OP_RW, 1'b1), "unlisted_write");
        send_req(make_req(12'h123, CSR_OP_RS, 1'b0), "unlisted_read");
        send_req(make_req(`CSR_ADDR_MSCRATCH, CSR_OP_RC, 1'b1), "unlisted_read");

        send_req(make_req(`CSR_ADDR_MSTALL, CSR_OP_RS, 1'b0), "drain_stall");
        send_held(make_req(`CSR_ADDR_MSTALL, CSR_OP_RS, 1'b0), "drain_stall",
                  $urandom_range(3, 10));
        send_req(make_req(`CSR_ADDR_MSTALL, CSR_OP_RS, 1'b0), "drain_stall");

        send_req(make_req(`CSR_ADDR_MINSTRET, CSR_OP_RS, 1'b0), "counters");
        idle(7);
        send_req(make_req(`CSR_ADDR_MINSTRET, CSR_OP_RC, 1'b1), "counters");
        send_req(make_req(`CSR_ADDR_MINSTRETH, CSR_OP_RS, 1'b0), "counters");
        send_req(make_req(`CSR_ADDR_MCYCLE, CSR_OP_RS, 1'b0), "counters");
        idle(5);
        send_req(make_req(`CSR_ADDR_MCYCLE, CSR_OP_RS, 1'b0), "counters");
        send_req(make_req(`CSR_ADDR_MCYCLEH, CSR_OP_RS, 1'b0), "counters");

        bp_on = 1'b1;
        for (int k = 0; k < N_BP; k++) begin
            r = make_req(bp_addr[$urandom_range(0, 7)], random_op(), 1'($urandom_range(0, 1)));
            send_req(r, "backpressure");
            idle($urandom_range(0, 2));
        end
        bp_on = 1'b0;

        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        idle(2);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+hdl
hdl/csr_pkg.sv
hdl/csr_issue_ctrl.sv
hdl/csr_counters.sv
hdl/csr_file.sv
hdl/csr_rsp_buffer.sv
hdl/csr_unit.sv
tests/csr_unit_tb.sv

// ==== Makefile ====
# Verilator build and run of the CSR unit testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f verilog.f --top-module csr_unit_tb -Mdir obj_dir
	./obj_dir/Vcsr_unit_tb | tee $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
